// File: all.f
csr_pkg.sv
csr_commit_if.sv
csr_irq_if.sv
csr_issue.sv
csr_regfile.sv
csr_timer.sv
csr_top.sv
tb_csr_top.sv

// File: run.sh
#!/bin/sh
# build and run the csr testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_csr_top -Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
    exit 0
fi
exit 1

// File: tb_csr_top.sv
`timescale 1ns/100ps

module tb_csr_top import csr_pkg::*;
();

    localparam int N_RAND      = 60;
    localparam int N_EXC       = 4;
    localparam int N_INSTS     = N_RAND + 6 + 1 + N_EXC * 7 + 9 + 4;
    localparam int CYCLE_LIMIT = 3 * N_INSTS + 2000 + 8;  // 2000 for the timer

    logic clk;
    logic rstn;
    logic stall;
    logic flush_in;
    logic inst_valid;
    csr_op_e op;
    csr_addr_t addr;
    word_t din;
    word_t mask;
    word_t pc;
    ecode_t ecode;
    esubcode_t esubcode;
    word_t evaddr;
    logic [8:0] hw_int;
    logic flush_out;
    logic int_flush;
    word_t redirect_pc;
    word_t dout;
    logic clk_stall;
    logic [8:0] crmd;
    logic excp_flush;
    logic ertn_flush;
    ecode_t ecode_out;

    // reference model state
    logic [8:0]  m_crmd;
    logic [2:0]  m_prmd;
    logic [12:0] m_lie;
    word_t m_era;
    word_t m_badv;
    word_t m_eentry;
    ecode_t m_ecode;
    word_t m_save [4];

    // outputs captured by one instruction
    word_t got_dout;
    word_t got_redirect;
    logic got_flush;
    logic got_int;
    logic got_stall;
    logic got_excp;
    logic got_ertn;
    ecode_t got_ecode;
    logic [8:0] got_crmd;

    word_t seed;
    int errs;
    int test_base;
    int tests_run;
    int tests_failed;
    int cycles;

    csr_top UUT (
        .clk         (clk),
        .rstn        (rstn),
        .stall       (stall),
        .flush_in    (flush_in),
        .inst_valid  (inst_valid),
        .op          (op),
        .addr        (addr),
        .din         (din),
        .mask        (mask),
        .pc          (pc),
        .ecode       (ecode),
        .esubcode    (esubcode),
        .evaddr      (evaddr),
        .hw_int      (hw_int),
        .flush_out   (flush_out),
        .int_flush   (int_flush),
        .redirect_pc (redirect_pc),
        .dout        (dout),
        .clk_stall   (clk_stall),
        .crmd        (crmd),
        .excp_flush  (excp_flush),
        .ertn_flush  (ertn_flush),
        .ecode_out   (ecode_out)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial
    begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display(">>> FAIL");
        $finish;
    end

    function word_t rnd();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function csr_addr_t rw_addr(input int k);
        case (k)
            0:       return CSR_SAVE0;
            1:       return CSR_SAVE1;
            2:       return CSR_SAVE2;
            3:       return CSR_SAVE3;
            4:       return CSR_ERA;
            default: return CSR_EENTRY;
        endcase
    endfunction

    function word_t model_read(input csr_addr_t a);
        case (a)
            CSR_CRMD:   return {23'b0, m_crmd};
            CSR_PRMD:   return {29'b0, m_prmd};
            CSR_ECFG:   return {19'b0, m_lie};
            CSR_ERA:    return m_era;
            CSR_BADV:   return m_badv;
            CSR_EENTRY: return m_eentry;
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                return m_save[a[1:0]];
            default:    return '0;
        endcase
    endfunction

    task model_write(input csr_addr_t a, input word_t v);
        case (a)
            CSR_CRMD:
            begin
                m_crmd[2:0] = v[2:0];
                m_crmd[8:5] = v[8:5];
                if (v[4] ^ v[3])
                    m_crmd[4:3] = v[4:3];
            end
            CSR_PRMD:   m_prmd = v[2:0];
            CSR_ECFG:   m_lie = {v[12:11], 1'b0, v[9:0]};
            CSR_ERA:    m_era = v;
            CSR_BADV:   m_badv = v;
            CSR_EENTRY: m_eentry = {v[31:6], 6'b0};
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                m_save[a[1:0]] = v;
            default: ;
        endcase
    endtask

    task model_excp(input ecode_t ec, input word_t p, input word_t ev, input logic in_idle);
        m_prmd = m_crmd[2:0];
        m_crmd[2:0] = 3'b0;
        if (!in_idle)
            m_era = p;  // era kept when woken from idle
        m_ecode = ec;
        if (ec == ECODE_ALE || ec == ECODE_ADE)
            m_badv = ev;
    endtask

    task check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            errs = errs + 1;
            $display("** Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task check_crmd(input string name, input logic [8:0] got, input logic [8:0] exp);
        if (got !== exp)
        begin
            errs = errs + 1;
            $display("** Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task check_ecode(input string name, input ecode_t got, input ecode_t exp);
        if (got !== exp)
        begin
            errs = errs + 1;
            $display("** Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            errs = errs + 1;
            $display("** Error at %0d ns: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task end_test(input string name);
        tests_run = tests_run + 1;
        if (errs == test_base)
            $display("test %s: ok", name);
        else
        begin
            tests_failed = tests_failed + 1;
            $display("test %s: failed with %0d mismatches", name, errs - test_base);
        end
        test_base = errs;
    endtask

    // one instruction sampled at the second edge
    task send(input csr_op_e o, input csr_addr_t a, input word_t d, input word_t m,
              input word_t p, input ecode_t ec, input esubcode_t es, input word_t ev,
              input logic fl);
        @(posedge clk);
        #2;
        op = o;
        addr = a;
        din = d;
        mask = m;
        pc = p;
        ecode = ec;
        esubcode = es;
        evaddr = ev;
        flush_in = fl;
        inst_valid = 1'b1;
        @(posedge clk);
        #2;
        inst_valid = 1'b0;
        flush_in = 1'b0;
        op = op_none;
        got_dout = dout;
        got_redirect = redirect_pc;
        got_flush = flush_out;
        got_int = int_flush;
        got_stall = clk_stall;
    endtask

    task settle();
        @(posedge clk);
        #2;
        got_excp = excp_flush;
        got_ertn = ertn_flush;
        got_ecode = ecode_out;
        got_crmd = crmd;
    endtask

    task do_op(input csr_op_e o, input csr_addr_t a, input word_t d, input word_t m,
               input word_t p, input ecode_t ec, input esubcode_t es, input word_t ev);
        send(o, a, d, m, p, ec, es, ev, 1'b0);
        settle();
    endtask

    task access(input csr_op_e o, input csr_addr_t a, input word_t d, input word_t m);
        do_op(o, a, d, m, rnd() & 32'hfffffffc, '0, '0, '0);
    endtask

    task read_csr(input csr_addr_t a, output word_t v);
        access(op_csrrd, a, '0, '0);
        v = got_dout;
    endtask

    initial
    begin
        csr_addr_t a;
        csr_op_e o;
        word_t v;
        word_t d;
        word_t m;
        word_t p;
        word_t ev;
        word_t old;
        word_t eff;
        word_t tinit;
        ecode_t ec;
        logic [1:0] plv;
        logic [8:0] old_crmd;
        logic seen;
        int k;
        int limit;
        int count;

        seed = 32'h30adf975;
        errs = 0;
        test_base = 0;
        tests_run = 0;
        tests_failed = 0;
        rstn = 1'b0;
        stall = 1'b0;
        flush_in = 1'b0;
        inst_valid = 1'b0;
        op = op_none;
        addr = '0;
        din = '0;
        mask = '0;
        pc = '0;
        ecode = '0;
        esubcode = '0;
        evaddr = '0;
        hw_int = '0;
        m_crmd = CRMD_RESET;
        m_prmd = '0;
        m_lie = '0;
        m_era = '0;
        m_badv = '0;
        m_eentry = '0;
        m_ecode = '0;
        for (int i = 0; i < 4; i++)
            m_save[i] = '0;

        repeat (8) @(posedge clk);
        #2;
        rstn = 1'b1;
        @(posedge clk);
        #2;
        check_crmd("crmd", crmd, CRMD_RESET);
        check_bit("flush_out", flush_out, 1'b0);
        check_bit("int_flush", int_flush, 1'b0);
        check_bit("excp_flush", excp_flush, 1'b0);
        check_bit("ertn_flush", ertn_flush, 1'b0);
        check_bit("clk_stall", clk_stall, 1'b0);
        check_ecode("ecode_out", ecode_out, '0);
        end_test("reset values");

        for (int i = 0; i < N_RAND; i++)
        begin
            a = rw_addr(rnd() % 6);
            k = rnd() % 3;
            o = (k == 0) ? op_csrrd : (k == 1) ? op_csrwr : op_csrxchg;
            d = rnd();
            m = rnd();
            old = model_read(a);
            access(o, a, d, m);
            check_word("dout", got_dout, old);
            check_bit("flush_out", got_flush, o != op_csrrd);
            if (o != op_csrrd)
            begin
                eff = (o == op_csrwr) ? '1 : m;
                model_write(a, (old & ~eff) | (d & eff));
            end
        end
        for (int i = 0; i < 6; i++)
        begin
            a = rw_addr(i);
            read_csr(a, v);
            check_word("readback", v, model_read(a));
        end
        end_test("random csr access");

        access(op_csrwr, CSR_EENTRY, rnd(), '1);
        model_write(CSR_EENTRY, din);
        for (int i = 0; i < N_EXC; i++)
        begin
            v = rnd();
            plv = (v[1:0] == 2'd0) ? 2'd3 : v[1:0];
            access(op_csrwr, CSR_CRMD, 32'h8 | {30'b0, plv}, '1);
            model_write(CSR_CRMD, 32'h8 | {30'b0, plv});
            check_crmd("crmd", got_crmd, m_crmd);
            v = rnd();
            case (v[1:0])
                2'd0:    ec = ECODE_ALE;
                2'd1:    ec = ECODE_ADE;
                default: ec = v[7:2];
            endcase
            p = rnd() & 32'hfffffffc;
            ev = rnd();
            do_op(op_excp, CSR_CRMD, '0, '0, p, ec, v[16:8], ev);
            check_word("redirect_pc", got_redirect, m_eentry);
            check_bit("flush_out", got_flush, 1'b1);
            check_bit("int_flush", got_int, 1'b0);
            check_bit("excp_flush", got_excp, 1'b1);
            check_bit("ertn_flush", got_ertn, 1'b0);
            check_ecode("ecode_out", got_ecode, ec);
            model_excp(ec, p, ev, 1'b0);
            check_crmd("crmd", got_crmd, m_crmd);
            read_csr(CSR_ERA, v);
            check_word("era", v, m_era);
            read_csr(CSR_PRMD, v);
            check_word("prmd", v, {29'b0, m_prmd});
            read_csr(CSR_BADV, v);
            check_word("badv", v, m_badv);
            read_csr(CSR_ESTAT, v);
            check_ecode("estat.ecode", v[21:16], m_ecode);
            access(op_ertn, CSR_CRMD, '0, '0);
            check_word("redirect_pc", got_redirect, m_era);
            check_bit("ertn_flush", got_ertn, 1'b1);
            check_bit("excp_flush", got_excp, 1'b0);
            m_crmd[2:0] = m_prmd;
            check_crmd("crmd", got_crmd, m_crmd);
        end
        end_test("exception entry and ertn");

        access(op_csrwr, CSR_ECFG, 32'h800, '1);  // timer line only
        model_write(CSR_ECFG, 32'h800);
        tinit = 32'd64 + (rnd() & 32'h3c);
        access(op_csrwr, CSR_TCFG, tinit | 32'h3, '1);
        access(op_csrwr, CSR_CRMD, 32'hc, '1);
        model_write(CSR_CRMD, 32'hc);
        check_crmd("crmd", got_crmd, m_crmd);
        access(op_idle, CSR_CRMD, '0, '0);
        check_bit("clk_stall", got_stall, 1'b1);
        // next instruction waits at the issue stage until the core wakes
        p = rnd() & 32'hfffffffc;
        op = op_csrrd;
        addr = CSR_SAVE0;
        pc = p;
        inst_valid = 1'b1;
        limit = tinit + 20;
        count = 0;
        seen = 1'b0;
        while (!seen && count < limit)
        begin
            @(posedge clk);
            #2;
            count = count + 1;
            seen = int_flush;
        end
        inst_valid = 1'b0;
        op = op_none;
        if (!seen)
        begin
            errs = errs + 1;
            $display("timer interrupt was not taken within %0d cycles of idle", limit);
        end
        else
        begin
            check_bit("clk_stall", clk_stall, 1'b0);
            check_word("redirect_pc", redirect_pc, m_eentry);
            settle();
            check_bit("excp_flush", got_excp, 1'b1);
            check_ecode("ecode_out", got_ecode, ECODE_INT);
            model_excp(ECODE_INT, p, '0, 1'b1);
            check_crmd("crmd", got_crmd, m_crmd);
        end
        read_csr(CSR_ESTAT, v);
        check_ecode("estat.ecode", v[21:16], ECODE_INT);
        check_bit("estat.is[11]", v[LIE_TI_BIT], 1'b1);
        read_csr(CSR_ERA, v);
        check_word("era", v, m_era);
        access(op_csrwr, CSR_TCFG, '0, '1);
        access(op_csrwr, CSR_TICLR, 32'h1, '1);
        read_csr(CSR_ESTAT, v);
        check_bit("estat.is[11]", v[LIE_TI_BIT], 1'b0);
        end_test("timer interrupt and idle");

        send(op_csrwr, CSR_SAVE1, rnd(), '1, '0, '0, '0, '0, 1'b1);
        check_bit("flush_out", got_flush, 1'b0);
        settle();
        read_csr(CSR_SAVE1, v);
        check_word("save1", v, m_save[1]);
        old_crmd = m_crmd;
        v = rnd();
        plv = (v[1:0] == 2'd0) ? 2'd2 : v[1:0];
        d = 32'h8 | {30'b0, plv};
        p = rnd() & 32'hfffffffc;
        @(posedge clk);
        #2;
        op = op_csrwr;
        addr = CSR_CRMD;
        din = d;
        mask = '1;
        pc = p;
        inst_valid = 1'b1;
        @(posedge clk);
        #2;
        // a read stays presented while stalled and must not be taken
        op = op_csrrd;
        addr = CSR_SAVE2;
        pc = p + 32'd16;
        stall = 1'b1;
        check_word("dout", dout, {23'b0, old_crmd});
        check_word("redirect_pc", redirect_pc, p + 32'd4);
        repeat (4)
        begin
            @(posedge clk);
            #2;
            check_word("dout", dout, {23'b0, old_crmd});
            check_word("redirect_pc", redirect_pc, p + 32'd4);
            check_bit("flush_out", flush_out, 1'b1);
            check_crmd("crmd", crmd, old_crmd);
        end
        stall = 1'b0;
        inst_valid = 1'b0;
        op = op_none;
        @(posedge clk);
        #2;
        model_write(CSR_CRMD, d);
        check_crmd("crmd", crmd, m_crmd);
        end_test("flush and stall");

        $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed, errs);
        if (errs == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// File: csr_top.sv
`timescale 1ns/100ps

module csr_top import csr_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       stall,
    input  logic       flush_in,
    input  logic       inst_valid,
    input  csr_op_e    op,
    input  csr_addr_t  addr,
    input  word_t      din,
    input  word_t      mask,
    input  word_t      pc,
    input  ecode_t     ecode,
    input  esubcode_t  esubcode,
    input  word_t      evaddr,
    input  logic [8:0] hw_int,
    output logic       flush_out,
    output logic       int_flush,
    output word_t      redirect_pc,
    output word_t      dout,
    output logic       clk_stall,
    output logic [8:0] crmd,
    output logic       excp_flush,
    output logic       ertn_flush,
    output ecode_t     ecode_out
);

    csr_addr_t rd_addr;
    word_t     rdata;
    word_t     tcfg;
    word_t     tval;

    csr_commit_if commit_bus ();
    csr_irq_if    irq_bus ();

    csr_issue u_issue (
        .clk         (clk),
        .rstn        (rstn),
        .stall       (stall),
        .flush_in    (flush_in),
        .inst_valid  (inst_valid),
        .op          (op),
        .addr        (addr),
        .din         (din),
        .mask        (mask),
        .pc          (pc),
        .ecode       (ecode),
        .esubcode    (esubcode),
        .evaddr      (evaddr),
        .rdata       (rdata),
        .hw_int      (hw_int),
        .rd_addr     (rd_addr),
        .flush_out   (flush_out),
        .int_flush   (int_flush),
        .redirect_pc (redirect_pc),
        .dout        (dout),
        .clk_stall   (clk_stall),
        .commit      (commit_bus.issue),
        .irq         (irq_bus.sink)
    );

    csr_regfile u_regfile (
        .clk        (clk),
        .rstn       (rstn),
        .stall      (stall),
        .rd_addr    (rd_addr),
        .hw_int     (hw_int),
        .tcfg       (tcfg),
        .tval       (tval),
        .rdata      (rdata),
        .crmd       (crmd),
        .excp_flush (excp_flush),
        .ertn_flush (ertn_flush),
        .ecode_out  (ecode_out),
        .commit     (commit_bus.regfile),
        .irq        (irq_bus.src)
    );

    csr_timer u_timer (
        .clk    (clk),
        .rstn   (rstn),
        .stall  (stall),
        .tcfg   (tcfg),
        .tval   (tval),
        .commit (commit_bus.timer),
        .irq    (irq_bus.src)
    );

endmodule

// File: csr_timer.sv
`timescale 1ns/100ps

module csr_timer import csr_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        stall,
    output word_t       tcfg,
    output word_t       tval,
    csr_commit_if.timer commit,
    csr_irq_if.src      irq
);

    logic csr_wr;
    logic tcfg_change;  // tcfg written last cycle
    logic ti_clear;

    assign csr_wr   = commit.run && !stall &&
                      (commit.op == op_csrwr || commit.op == op_csrxchg);
    assign ti_clear = csr_wr && commit.addr == CSR_TICLR && commit.wdata[0];

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tcfg        <= '0;
            tcfg_change <= 1'b0;
        end
        else
        begin
            tcfg_change <= 1'b0;
            if (csr_wr && commit.addr == CSR_TCFG)
            begin
                tcfg        <= commit.wdata;
                tcfg_change <= 1'b1;
            end
        end
    end

    // tcfg[0] enable, tcfg[1] periodic
    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            tval   <= '0;
            irq.ti <= 1'b0;
        end
        else
        begin
            if (ti_clear)
                irq.ti <= 1'b0;
            else if (tval == '0 && tcfg[0] && !tcfg_change)
                irq.ti <= 1'b1;

            if ((tval == '0 && tcfg[1]) || (tcfg[0] && tcfg_change))
                tval <= {tcfg[31:2], 2'b0};
            else if (!tcfg[0])
                tval <= '0;
            else if (tval != '1)
                tval <= tval - 32'd1;  // one-shot parks at all-ones
        end
    end

endmodule

// File: csr_regfile.sv
`timescale 1ns/100ps

module csr_regfile import csr_pkg::*;
(
    input  logic          clk,
    input  logic          rstn,
    input  logic          stall,
    input  csr_addr_t     rd_addr,
    input  logic [8:0]    hw_int,
    input  word_t         tcfg,
    input  word_t         tval,
    output word_t         rdata,
    output logic [8:0]    crmd,
    output logic          excp_flush,
    output logic          ertn_flush,
    output ecode_t        ecode_out,
    csr_commit_if.regfile commit,
    csr_irq_if.src        irq
);

    logic        commit_en;
    logic [8:0]  crmd_q;
    logic [2:0]  prmd_q;
    logic [12:0] lie_q;      // bit 10 stays 0
    logic [1:0]  estat_is;
    ecode_t      estat_ecode;
    esubcode_t   estat_esub;
    word_t       era_q;
    word_t       badv_q;
    logic [31:6] eentry_q;
    word_t       save_q [4];
    word_t       tid_q;

    assign commit_en = commit.run && !stall;

    assign crmd       = crmd_q;
    assign ecode_out  = excp_flush ? estat_ecode : '0;
    assign irq.ie     = crmd_q[2];
    assign irq.lie    = lie_q;
    assign irq.swi    = estat_is;
    assign irq.eentry = {eentry_q, 6'b0};
    assign irq.era    = era_q;

    always_comb
    begin
        case (rd_addr)
            CSR_CRMD:   rdata = {23'b0, crmd_q};
            CSR_PRMD:   rdata = {29'b0, prmd_q};
            CSR_ECFG:   rdata = {19'b0, lie_q};
            CSR_ESTAT:  rdata = {1'b0, estat_esub, estat_ecode, 3'b0,
                                 hw_int[8], irq.ti, 1'b0, hw_int[7:0], estat_is};
            CSR_ERA:    rdata = era_q;
            CSR_BADV:   rdata = badv_q;
            CSR_EENTRY: rdata = {eentry_q, 6'b0};
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                rdata = save_q[rd_addr[1:0]];
            CSR_TID:    rdata = tid_q;
            CSR_TCFG:   rdata = tcfg;
            CSR_TVAL:   rdata = tval;
            default:    rdata = '0;  // ticlr and unknown
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            crmd_q      <= CRMD_RESET;
            prmd_q      <= '0;
            lie_q       <= '0;
            estat_is    <= '0;
            estat_ecode <= '0;
            estat_esub  <= '0;
            era_q       <= '0;
            badv_q      <= '0;
            eentry_q    <= '0;
            save_q[0]   <= '0;
            save_q[1]   <= '0;
            save_q[2]   <= '0;
            save_q[3]   <= '0;
            tid_q       <= '0;
            excp_flush  <= 1'b0;
            ertn_flush  <= 1'b0;
        end
        else
        begin
            excp_flush <= 1'b0;
            ertn_flush <= 1'b0;
            if (commit_en)
            begin
                case (commit.op)
                    op_csrwr, op_csrxchg:
                    begin
                        case (commit.addr)
                            CSR_CRMD:
                            begin
                                crmd_q[2:0] <= commit.wdata[2:0];
                                crmd_q[8:5] <= commit.wdata[8:5];
                                if (commit.wdata[4] ^ commit.wdata[3])  // da/pg one-hot
                                    crmd_q[4:3] <= commit.wdata[4:3];
                            end
                            CSR_PRMD:   prmd_q   <= commit.wdata[2:0];
                            CSR_ECFG:   lie_q    <= {commit.wdata[12:11], 1'b0,
                                                     commit.wdata[9:0]};
                            CSR_ESTAT:  estat_is <= commit.wdata[1:0];  // only swi writable
                            CSR_ERA:    era_q    <= commit.wdata;
                            CSR_BADV:   badv_q   <= commit.wdata;
                            CSR_EENTRY: eentry_q <= commit.wdata[31:6];
                            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3:
                                save_q[commit.addr[1:0]] <= commit.wdata;
                            CSR_TID:    tid_q    <= commit.wdata;
                            default: ;
                        endcase
                    end
                    op_ertn:
                    begin
                        crmd_q[2:0] <= prmd_q;
                        ertn_flush  <= 1'b1;
                    end
                    op_excp, op_int:
                    begin
                        prmd_q      <= crmd_q[2:0];
                        crmd_q[2:0] <= 3'b0;  // plv 0, ie off
                        if (!commit.old_clk_stall)
                            era_q <= commit.pc;
                        estat_ecode <= commit.ecode;
                        estat_esub  <= commit.esubcode;
                        if (commit.ecode == ECODE_ALE || commit.ecode == ECODE_ADE)
                            badv_q <= commit.badv;
                        excp_flush  <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    a_flush_excl: assert property (@(posedge clk) disable iff (!rstn)
        !(excp_flush && ertn_flush));

endmodule

// File: csr_issue.sv
`timescale 1ns/100ps

module csr_issue import csr_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        stall,
    input  logic        flush_in,
    input  logic        inst_valid,
    input  csr_op_e     op,
    input  csr_addr_t   addr,
    input  word_t       din,
    input  word_t       mask,
    input  word_t       pc,
    input  ecode_t      ecode,
    input  esubcode_t   esubcode,
    input  word_t       evaddr,
    input  word_t       rdata,
    input  logic [8:0]  hw_int,
    output csr_addr_t   rd_addr,
    output logic        flush_out,
    output logic        int_flush,
    output word_t       redirect_pc,
    output word_t       dout,
    output logic        clk_stall,
    csr_commit_if.issue commit,
    csr_irq_if.sink     irq
);

    logic        accept;
    logic        int_pending;
    logic        int_block;    // exception/interrupt still on its way to commit
    logic [12:0] pend_vec;
    csr_op_e     op_eff;
    ecode_t      ecode_eff;
    esubcode_t   esub_eff;
    word_t       wmask;
    word_t       npc;
    logic        need_flush;

    assign rd_addr = addr;
    assign accept  = inst_valid && !stall && !flush_in;

    // same layout as estat.is with bit 10 unused
    always_comb
    begin
        pend_vec = {hw_int[8], 1'b0, 1'b0, hw_int[7:0], irq.swi};
        pend_vec[LIE_TI_BIT] = irq.ti;
    end

    assign int_pending = irq.ie && !int_block && |(pend_vec & irq.lie);

    // interrupt wins over whatever the pipeline hands in
    assign op_eff    = int_pending ? op_int : op;
    assign ecode_eff = int_pending ? ECODE_INT : ecode;
    assign esub_eff  = int_pending ? '0 : esubcode;

    assign wmask      = (op_eff == op_csrxchg) ? mask : '1;
    assign need_flush = (op_eff != op_none) && (op_eff != op_csrrd);

    always_comb
    begin
        case (op_eff)
            op_ertn:         npc = irq.era;
            op_excp, op_int: npc = irq.eentry;
            default:         npc = pc + 32'd4;
        endcase
    end

    // control half of the stage register
    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            commit.run <= 1'b0;
            flush_out  <= 1'b0;
            int_flush  <= 1'b0;
            int_block  <= 1'b0;
        end
        else if (!stall)
        begin
            commit.run <= accept;
            flush_out  <= accept && need_flush;
            int_flush  <= accept && int_pending;
            int_block  <= accept && (op_eff == op_excp || op_eff == op_int);
        end
    end

    // payload only loaded by a sampled instruction
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            commit.op            <= op_eff;
            commit.addr          <= addr;
            commit.wdata         <= (rdata & ~wmask) | (din & wmask);
            commit.pc            <= pc;
            commit.ecode         <= ecode_eff;
            commit.esubcode      <= esub_eff;
            commit.badv          <= evaddr;
            commit.old_clk_stall <= clk_stall;
            dout                 <= rdata;  // old csr value
            redirect_pc          <= npc;
        end
    end

    // idle gates the core clock until an enabled interrupt shows up
    always_ff @(posedge clk)
    begin
        if (!rstn)
            clk_stall <= 1'b0;
        else if (accept && op_eff == op_idle)
            clk_stall <= 1'b1;
        else if (int_pending)
            clk_stall <= 1'b0;
    end

    a_flush_src: assert property (@(posedge clk) disable iff (!rstn)
        (flush_out || int_flush) |-> $past(accept || stall));

endmodule

// File: csr_irq_if.sv
`timescale 1ns/100ps

interface csr_irq_if import csr_pkg::*;
();
    logic        ie;      // crmd.ie
    logic [12:0] lie;     // ecfg local enables
    logic [1:0]  swi;     // software lines from estat.is
    word_t       eentry;
    word_t       era;
    logic        ti;      // timer pending

    // regfile drives everything but ti, which comes from the timer
    modport src (output ie, lie, swi, eentry, era, ti);

    modport sink (input ie, lie, swi, eentry, era, ti);

endinterface

// File: csr_commit_if.sv
`timescale 1ns/100ps

interface csr_commit_if import csr_pkg::*;
();
    logic      run;            // registered op valid this cycle
    csr_op_e   op;
    csr_addr_t addr;
    word_t     wdata;          // already merged with mask
    word_t     pc;
    ecode_t    ecode;
    esubcode_t esubcode;
    word_t     badv;
    logic      old_clk_stall;  // core was idling at issue

    modport issue (
        output run, op, addr, wdata, pc, ecode, esubcode, badv, old_clk_stall
    );

    modport regfile (
        input run, op, addr, wdata, pc, ecode, esubcode, badv, old_clk_stall
    );

    modport timer (
        input run, op, addr, wdata
    );

endinterface

// File: csr_pkg.sv
package csr_pkg;

    typedef logic [31:0] word_t;
    typedef logic [13:0] csr_addr_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;

    // op_int comes from the issue stage and never from the pipeline
    typedef enum logic [2:0] {
        op_none,
        op_csrrd,
        op_csrwr,
        op_csrxchg,
        op_ertn,
        op_idle,
        op_excp,
        op_int
    } csr_op_e;

    localparam csr_addr_t CSR_CRMD   = 14'h000;
    localparam csr_addr_t CSR_PRMD   = 14'h001;
    localparam csr_addr_t CSR_ECFG   = 14'h004;
    localparam csr_addr_t CSR_ESTAT  = 14'h005;
    localparam csr_addr_t CSR_ERA    = 14'h006;
    localparam csr_addr_t CSR_BADV   = 14'h007;
    localparam csr_addr_t CSR_EENTRY = 14'h00c;
    localparam csr_addr_t CSR_SAVE0  = 14'h030;
    localparam csr_addr_t CSR_SAVE1  = 14'h031;
    localparam csr_addr_t CSR_SAVE2  = 14'h032;
    localparam csr_addr_t CSR_SAVE3  = 14'h033;
    localparam csr_addr_t CSR_TID    = 14'h040;
    localparam csr_addr_t CSR_TCFG   = 14'h041;
    localparam csr_addr_t CSR_TVAL   = 14'h042;
    localparam csr_addr_t CSR_TICLR  = 14'h044;

    localparam ecode_t ECODE_INT = 6'h00;
    localparam ecode_t ECODE_ADE = 6'h08;
    localparam ecode_t ECODE_ALE = 6'h09;

    localparam logic [8:0] CRMD_RESET = 9'h008;  // plv 0, ie 0, da 1

    localparam int LIE_TI_BIT = 11;  // timer line in ecfg.lie / estat.is

endpackage
